//--- rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path and address width
`define ISA_WIDTH 32

// Register index, 32 architectural registers
`define REG_ADDR_WIDTH 5

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// Cycle and retire counters
`define COUNT_WIDTH 32

`endif

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef enum logic [3:0] {
        INST_AUIPC,
        INST_JAL,
        INST_JALR,
        INST_BEQ,
        INST_BNE,
        INST_LW,
        INST_SW,
        INST_ADDI,
        INST_SLTIU,
        INST_ADD,
        INST_SUB,
        INST_EBREAK,
        INST_ILLEGAL
    } inst_num_e;

    typedef enum logic [2:0] {
        TYPE_NONE,
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J
    } inst_type_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_SLTU} alu_op_e;

    typedef enum logic [1:0] {ST_BOOT, ST_RUN, ST_HALT} ctrl_state_e;

endpackage

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_decode (
    input  wire [`ISA_WIDTH-1:0]      inst,
    output rv_pkg::inst_num_e         inst_num,
    output rv_pkg::inst_type_e        inst_type,
    output logic [`ISA_WIDTH-1:0]     imm,
    output logic [`REG_ADDR_WIDTH-1:0] rs1,
    output logic [`REG_ADDR_WIDTH-1:0] rs2,
    output logic [`REG_ADDR_WIDTH-1:0] rd,
    output rv_pkg::alu_op_e           alu_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        inst_num  = rv_pkg::INST_ILLEGAL;
        inst_type = rv_pkg::TYPE_NONE;
        case (opcode)
            7'b0010111: begin
                inst_num  = rv_pkg::INST_AUIPC;
                inst_type = rv_pkg::TYPE_U;
            end
            7'b1101111: begin
                inst_num  = rv_pkg::INST_JAL;
                inst_type = rv_pkg::TYPE_J;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) begin
                    inst_num  = rv_pkg::INST_JALR;
                    inst_type = rv_pkg::TYPE_I;
                end
            end
            7'b1100011: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    inst_num  = (funct3 == 3'b000) ? rv_pkg::INST_BEQ : rv_pkg::INST_BNE;
                    inst_type = rv_pkg::TYPE_B;
                end
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin // Word loads only
                    inst_num  = rv_pkg::INST_LW;
                    inst_type = rv_pkg::TYPE_I;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    inst_num  = rv_pkg::INST_SW;
                    inst_type = rv_pkg::TYPE_S;
                end
            end
            7'b0010011: begin
                if (funct3 == 3'b000 || funct3 == 3'b011) begin
                    inst_num  = (funct3 == 3'b000) ? rv_pkg::INST_ADDI : rv_pkg::INST_SLTIU;
                    inst_type = rv_pkg::TYPE_I;
                end
            end
            7'b0110011: begin
                if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
                    inst_num  = funct7[5] ? rv_pkg::INST_SUB : rv_pkg::INST_ADD;
                    inst_type = rv_pkg::TYPE_R;
                end
            end
            7'b1110011: begin
                if (inst == 32'h0010_0073) begin // Exact ebreak encoding
                    inst_num  = rv_pkg::INST_EBREAK;
                    inst_type = rv_pkg::TYPE_I;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (inst_type)
            rv_pkg::TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::TYPE_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::TYPE_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::TYPE_U: imm = {inst[31:12], 12'b0};
            rv_pkg::TYPE_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

    always_comb begin
        case (inst_num)
            rv_pkg::INST_BEQ,
            rv_pkg::INST_BNE,
            rv_pkg::INST_SUB:   alu_op = rv_pkg::ALU_SUB; // Branch compare reuses subtract
            rv_pkg::INST_SLTIU: alu_op = rv_pkg::ALU_SLTU;
            default:            alu_op = rv_pkg::ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_regfile (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [`REG_ADDR_WIDTH-1:0] rs1,
    input  wire [`REG_ADDR_WIDTH-1:0] rs2,
    output logic [`ISA_WIDTH-1:0]     src1,
    output logic [`ISA_WIDTH-1:0]     src2,
    input  wire                       w_en,
    input  wire [`REG_ADDR_WIDTH-1:0] rd,
    input  wire [`ISA_WIDTH-1:0]      w_data
);

    localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

    logic [`ISA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && rd != '0) begin // x0 never written
            regs[rd] <= w_data;
        end
    end

    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_alu (
    input  wire rv_pkg::alu_op_e   alu_op,
    input  wire rv_pkg::inst_num_e inst_num,
    input  wire [`ISA_WIDTH-1:0]   a,
    input  wire [`ISA_WIDTH-1:0]   b,
    output logic [`ISA_WIDTH-1:0]  alu_result,
    output logic                   br_cond
);

    logic [`ISA_WIDTH-1:0] sum;
    logic [`ISA_WIDTH-1:0] diff;
    logic                  lt_u;
    logic                  is_zero;

    assign sum     = a + b; // Also the lw/sw address
    assign diff    = a - b;
    assign lt_u    = a < b;
    assign is_zero = (diff == '0);

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_SUB:  alu_result = diff;
            rv_pkg::ALU_SLTU: alu_result = {{(`ISA_WIDTH-1){1'b0}}, lt_u};
            default:          alu_result = sum;
        endcase
    end

    // Taken condition for beq, inverted for bne
    assign br_cond = (inst_num == rv_pkg::INST_BNE) ? ~is_zero : is_zero;

endmodule

`default_nettype wire

//--- rv_exu_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_exu_pc (
    input  wire rv_pkg::inst_num_e  inst_num,
    input  wire rv_pkg::inst_type_e inst_type,
    input  wire [`ISA_WIDTH-1:0]    imm,
    input  wire [`ISA_WIDTH-1:0]    pc,
    input  wire [`ISA_WIDTH-1:0]    src1,
    input  wire                     br_cond,
    output logic [`ISA_WIDTH-1:0]   next_pc,
    output logic                    pc_valid_type
);

    logic [`ISA_WIDTH-1:0] adder_a;
    logic [`ISA_WIDTH-1:0] adder_b;
    logic [`ISA_WIDTH-1:0] adder_s;
    logic                  is_jalr;

    always_comb begin
        adder_a = pc;
        adder_b = `ISA_WIDTH'd4;
        case (inst_num)
            rv_pkg::INST_JAL: begin
                adder_b = imm;
            end
            rv_pkg::INST_JALR: begin
                adder_a = src1;
                adder_b = imm;
            end
            rv_pkg::INST_BEQ,
            rv_pkg::INST_BNE: begin
                adder_b = br_cond ? imm : `ISA_WIDTH'd4;
            end
            default: ;
        endcase
    end

    assign adder_s = adder_a + adder_b;
    assign is_jalr = (inst_num == rv_pkg::INST_JALR);
    assign next_pc = {adder_s[`ISA_WIDTH-1:1], adder_s[0] & ~is_jalr};

    always_comb begin
        case (inst_type)
            rv_pkg::TYPE_R, rv_pkg::TYPE_I, rv_pkg::TYPE_S,
            rv_pkg::TYPE_B, rv_pkg::TYPE_U, rv_pkg::TYPE_J: pc_valid_type = 1'b1;
            default:                                          pc_valid_type = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_fsm (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rv_pkg::inst_num_e inst_num,
    input  wire                    pc_valid_type,
    output rv_pkg::ctrl_state_e    state,
    output logic                   pc_w_en,
    output logic                   reg_w_en_gate,
    output logic                   mem_w_en_gate,
    output logic                   halted
);

    rv_pkg::ctrl_state_e state_nxt;
    logic                is_ebreak;
    logic                exec_ok;

    assign is_ebreak = (inst_num == rv_pkg::INST_EBREAK);

    always_comb begin
        state_nxt = state;
        case (state)
            rv_pkg::ST_BOOT: state_nxt = rv_pkg::ST_RUN;
            rv_pkg::ST_RUN:  if (is_ebreak) state_nxt = rv_pkg::ST_HALT;
            default:         state_nxt = rv_pkg::ST_HALT; // Only reset leaves halt
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rv_pkg::ST_BOOT;
        end else begin
            state <= state_nxt;
        end
    end

    // Illegal opcodes fall out through pc_valid_type
    assign exec_ok       = (state == rv_pkg::ST_RUN) && pc_valid_type && !is_ebreak;
    assign pc_w_en       = exec_ok;
    assign reg_w_en_gate = exec_ok;
    assign mem_w_en_gate = exec_ok;
    assign halted        = (state == rv_pkg::ST_HALT);

endmodule

`default_nettype wire

//--- rv_perf_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_perf_counter (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire rv_pkg::ctrl_state_e state,
    input  wire                      retire,
    output logic [`COUNT_WIDTH-1:0]  cycle_count,
    output logic [`COUNT_WIDTH-1:0]  instret_count
);

    logic running;

    assign running = (state == rv_pkg::ST_RUN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else if (running) begin
            cycle_count <= cycle_count + 1'b1;
            if (retire) instret_count <= instret_count + 1'b1; // Excludes ebreak and illegal
        end
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_core (
    input  wire                      clk,
    input  wire                      rst_n,
    output logic [`ISA_WIDTH-1:0]    imem_addr,
    input  wire [`ISA_WIDTH-1:0]     imem_data,
    output logic [`ISA_WIDTH-1:0]    dmem_addr,
    output logic [`ISA_WIDTH-1:0]    dmem_wdata,
    output logic                     dmem_we,
    input  wire [`ISA_WIDTH-1:0]     dmem_rdata,
    output logic                     halted,
    output logic [`COUNT_WIDTH-1:0]  cycle_count,
    output logic [`COUNT_WIDTH-1:0]  instret_count
);

    logic [`ISA_WIDTH-1:0]      pc;
    logic [`ISA_WIDTH-1:0]      next_pc;
    rv_pkg::inst_num_e          inst_num;
    rv_pkg::inst_type_e         inst_type;
    rv_pkg::alu_op_e            alu_op;
    rv_pkg::ctrl_state_e        state;
    logic [`ISA_WIDTH-1:0]      imm;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`ISA_WIDTH-1:0]      src1;
    logic [`ISA_WIDTH-1:0]      src2;
    logic [`ISA_WIDTH-1:0]      alu_b;
    logic [`ISA_WIDTH-1:0]      alu_result;
    logic [`ISA_WIDTH-1:0]      wb_data;
    logic                       br_cond;
    logic                       pc_valid_type;
    logic                       pc_w_en;
    logic                       reg_w_en_gate;
    logic                       mem_w_en_gate;
    logic                       dec_reg_we;
    logic                       reg_w_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (pc_w_en) begin
            pc <= next_pc;
        end
    end

    assign imem_addr = pc;

    rv_decode i_rv_decode (
        .inst      (imem_data),
        .inst_num  (inst_num),
        .inst_type (inst_type),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .alu_op    (alu_op)
    );

    rv_regfile i_rv_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .src1   (src1),
        .src2   (src2),
        .w_en   (reg_w_en),
        .rd     (rd),
        .w_data (wb_data)
    );

    // Immediate for I and S formats, register otherwise
    assign alu_b = (inst_type == rv_pkg::TYPE_I || inst_type == rv_pkg::TYPE_S) ? imm : src2;

    rv_alu i_rv_alu (
        .alu_op     (alu_op),
        .inst_num   (inst_num),
        .a          (src1),
        .b          (alu_b),
        .alu_result (alu_result),
        .br_cond    (br_cond)
    );

    rv_exu_pc i_rv_exu_pc (
        .inst_num      (inst_num),
        .inst_type     (inst_type),
        .imm           (imm),
        .pc            (pc),
        .src1          (src1),
        .br_cond       (br_cond),
        .next_pc       (next_pc),
        .pc_valid_type (pc_valid_type)
    );

    rv_ctrl_fsm i_rv_ctrl_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_num      (inst_num),
        .pc_valid_type (pc_valid_type),
        .state         (state),
        .pc_w_en       (pc_w_en),
        .reg_w_en_gate (reg_w_en_gate),
        .mem_w_en_gate (mem_w_en_gate),
        .halted        (halted)
    );

    rv_perf_counter i_rv_perf_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .retire        (pc_w_en),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    always_comb begin
        case (inst_num)
            rv_pkg::INST_JAL,
            rv_pkg::INST_JALR:  wb_data = pc + `ISA_WIDTH'd4; // Link address
            rv_pkg::INST_AUIPC: wb_data = pc + imm;
            rv_pkg::INST_LW:    wb_data = dmem_rdata;
            default:            wb_data = alu_result;
        endcase
    end

    // S and B formats never write rd
    assign dec_reg_we = (inst_type == rv_pkg::TYPE_R) || (inst_type == rv_pkg::TYPE_I) ||
                        (inst_type == rv_pkg::TYPE_U) || (inst_type == rv_pkg::TYPE_J);
    assign reg_w_en   = dec_reg_we && reg_w_en_gate;

    assign dmem_addr  = alu_result;
    assign dmem_wdata = src2;
    assign dmem_we    = mem_w_en_gate && (inst_num == rv_pkg::INST_SW);

endmodule

`default_nettype wire

//--- tb_rv_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_properties (
    input wire                      clk,
    input wire                      rst_n,
    input wire rv_pkg::ctrl_state_e state,
    input wire [`ISA_WIDTH-1:0]     imem_addr,
    input wire                      dmem_we,
    input wire [`COUNT_WIDTH-1:0]   cycle_count,
    input wire [`COUNT_WIDTH-1:0]   instret_count
);

    int prop_failures = 0;

    // PC and retire count frozen once halted
    halt_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        state == rv_pkg::ST_HALT |=> $stable(imem_addr) && $stable(instret_count))
        else begin
            $error("PC or retire count moved while halted");
            prop_failures++;
        end

    store_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        state != rv_pkg::ST_RUN |-> !dmem_we)
        else begin
            $error("Data write strobe high outside RUN");
            prop_failures++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("Fetch address is not word aligned");
            prop_failures++;
        end

    cycle_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> cycle_count >= $past(cycle_count))
        else begin
            $error("Cycle counter went backwards");
            prop_failures++;
        end

endmodule

bind rv_core tb_rv_properties i_tb_rv_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .state         (state),
    .imem_addr     (imem_addr),
    .dmem_we       (dmem_we),
    .cycle_count   (cycle_count),
    .instret_count (instret_count)
);

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;

    localparam int MAX_PROG  = 16;
    localparam int LIMIT     = 4 * MAX_PROG + 20;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic                    clk;
    logic                    rst_n;
    logic [`ISA_WIDTH-1:0]   imem_addr;
    logic [`ISA_WIDTH-1:0]   imem_data;
    logic [`ISA_WIDTH-1:0]   dmem_addr;
    logic [`ISA_WIDTH-1:0]   dmem_wdata;
    logic                    dmem_we;
    logic [`ISA_WIDTH-1:0]   dmem_rdata;
    logic                    halted;
    logic [`COUNT_WIDTH-1:0] cycle_count;
    logic [`COUNT_WIDTH-1:0] instret_count;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] prog [$];
    logic [31:0] lfsr_state = 32'hdd48;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    rv_core i_rv_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_we       (dmem_we),
        .dmem_rdata    (dmem_rdata),
        .halted        (halted),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Same-cycle memories
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    // Holds reset and refills both memories
    task automatic hold_reset();
        for (int i = 0; i < 64; i++) begin
            imem[i] = EBREAK;
            dmem[i] <= (32'(i) * 32'h0101_0101) ^ 32'ha5a5_0000;
        end
        prog.delete();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic release_reset();
        foreach (prog[i]) imem[i] = prog[i];
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                $display("Core did not halt within %0d cycles", LIMIT);
                $display("TESTS FAILED");
                $finish;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) tests_failed++;
        $display("%-12s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "bad", test_errors);
        test_errors = 0;
    endtask

    task automatic reset_test();
        hold_reset();
        @(negedge clk);
        check_eq("imem_addr", imem_addr, `RESET_PC);
        check_eq("dmem_we", 32'(dmem_we), 0);
        check_eq("halted", 32'(halted), 0);
        check_eq("cycle_count", cycle_count, 0);
        check_eq("instret_count", instret_count, 0);
        prog.push_back(EBREAK);
        release_reset();
        @(negedge clk);
        check_eq("imem_addr", imem_addr, `RESET_PC);
        check_eq("dmem_we", 32'(dmem_we), 0);
        check_eq("halted", 32'(halted), 0);
        check_eq("cycle_count", cycle_count, 0);
        check_eq("instret_count", instret_count, 0);
        wait_halt();
        finish_test("reset");
    endtask

    task automatic arith_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] k1;
        logic [11:0] k2;
        a  = rand_bits(32);
        b  = rand_bits(32);
        k1 = 12'(rand_bits(12));
        k2 = 12'(rand_bits(12));
        hold_reset();
        dmem[0] <= a;
        dmem[1] <= b;
        prog.push_back(i_type(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));
        prog.push_back(i_type(12'd4, 5'd0, 3'b010, 5'd2, 7'b0000011));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 5'd3));
        prog.push_back(r_type(7'h20, 5'd2, 5'd1, 5'd4));
        prog.push_back(i_type(k1, 5'd1, 3'b011, 5'd5, 7'b0010011));
        prog.push_back(i_type(k2, 5'd1, 3'b000, 5'd6, 7'b0010011));
        for (int r = 3; r <= 6; r++) prog.push_back(s_type(12'(4 * (r - 1)), 5'(r), 5'd0));
        prog.push_back(EBREAK);
        release_reset();
        wait_halt();
        check_eq("dmem[2] add", dmem[2], a + b);
        check_eq("dmem[3] sub", dmem[3], a - b);
        check_eq("dmem[4] sltiu", dmem[4], (a < {{20{k1[11]}}, k1}) ? 32'd1 : 32'd0);
        check_eq("dmem[5] addi", dmem[5], a + {{20{k2[11]}}, k2});
        check_eq("instret_count", instret_count, 32'd10);
        finish_test("arith_mem");
    endtask

    task automatic branch_test();
        logic [31:0] a;
        a = rand_bits(32);
        hold_reset();
        dmem[0] <= a;
        dmem[1] <= a ^ 32'h1;
        prog.push_back(i_type(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));
        prog.push_back(i_type(12'd0, 5'd0, 3'b010, 5'd2, 7'b0000011));
        prog.push_back(i_type(12'd4, 5'd0, 3'b010, 5'd3, 7'b0000011));
        prog.push_back(b_type(13'd8, 5'd2, 5'd1, 3'b000)); // beq taken
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd11, 7'b0010011));
        prog.push_back(b_type(13'd8, 5'd3, 5'd1, 3'b000)); // beq falls through
        prog.push_back(i_type(12'h022, 5'd0, 3'b000, 5'd12, 7'b0010011));
        prog.push_back(b_type(13'd8, 5'd3, 5'd1, 3'b001)); // bne taken
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd13, 7'b0010011));
        prog.push_back(b_type(13'd8, 5'd2, 5'd1, 3'b001)); // bne falls through
        prog.push_back(i_type(12'h044, 5'd0, 3'b000, 5'd14, 7'b0010011));
        for (int r = 11; r <= 14; r++) prog.push_back(s_type(12'(4 * (r - 9)), 5'(r), 5'd0));
        prog.push_back(EBREAK);
        release_reset();
        wait_halt();
        check_eq("dmem[2] beq taken", dmem[2], 32'h0);
        check_eq("dmem[3] beq not taken", dmem[3], 32'h22);
        check_eq("dmem[4] bne taken", dmem[4], 32'h0);
        check_eq("dmem[5] bne not taken", dmem[5], 32'h44);
        finish_test("branches");
    endtask

    task automatic jump_test();
        hold_reset();
        prog.push_back({20'h12345, 5'd5, 7'b0010111});                      // pc 0 auipc
        prog.push_back(j_type(21'd12, 5'd1));                               // pc 4 jal to 16
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd10, 7'b0010011));
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd10, 7'b0010011));
        prog.push_back(i_type(12'd30, 5'd0, 3'b000, 5'd6, 7'b0010011));     // pc 16
        prog.push_back(i_type(12'd3, 5'd6, 3'b000, 5'd7, 7'b1100111));      // jalr 33 lands 32
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd11, 7'b0010011));
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd11, 7'b0010011));
        prog.push_back({20'h00001, 5'd8, 7'b0010111});                      // pc 32 auipc
        prog.push_back(s_type(12'd0, 5'd1, 5'd0));
        prog.push_back(s_type(12'd4, 5'd7, 5'd0));
        prog.push_back(s_type(12'd8, 5'd5, 5'd0));
        prog.push_back(s_type(12'd12, 5'd8, 5'd0));
        prog.push_back(s_type(12'd16, 5'd10, 5'd0));
        prog.push_back(s_type(12'd20, 5'd11, 5'd0));
        prog.push_back(EBREAK);
        release_reset();
        wait_halt();
        check_eq("dmem[0] jal link", dmem[0], 32'd4 + 32'd4);
        check_eq("dmem[1] jalr link", dmem[1], 32'd20 + 32'd4);
        check_eq("dmem[2] auipc", dmem[2], 32'd0 + 32'h1234_5000);
        check_eq("dmem[3] auipc", dmem[3], 32'd32 + 32'h0000_1000);
        check_eq("dmem[4] jal skip", dmem[4], 32'h0);
        check_eq("dmem[5] jalr skip", dmem[5], 32'h0);
        finish_test("jumps");
    endtask

    task automatic halt_test();
        int n;
        int retired;
        n = int'(rand_bits(3) % 6) + 2;
        hold_reset();
        prog.push_back(i_type(12'(n), 5'd0, 3'b000, 5'd1, 7'b0010011));
        prog.push_back(i_type(12'hfff, 5'd1, 3'b000, 5'd1, 7'b0010011));   // x1 -= 1
        prog.push_back(b_type(13'h1ffc, 5'd0, 5'd1, 3'b001));              // back while x1 != 0
        prog.push_back(EBREAK);
        retired = 1 + 2 * n; // One setup, then addi and bne per pass
        release_reset();
        wait_halt();
        check_eq("imem_addr", imem_addr, 32'd12);
        check_eq("instret_count", instret_count, 32'(retired));
        check_eq("cycle_count", cycle_count, 32'(retired + 1));
        repeat (3) @(negedge clk);
        check_eq("halted", 32'(halted), 32'd1);
        check_eq("imem_addr", imem_addr, 32'd12);
        finish_test("halt_count");
    endtask

    initial begin
        rst_n        = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_test();
        arith_test();
        branch_test();
        jump_test();
        halt_test();
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0 && i_rv_core.i_tb_rv_properties.prop_failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_exu_pc.sv
rv_ctrl_fsm.sv
rv_perf_counter.sv
rv_core.sv
tb_rv_properties.sv
tb_rv_core.sv

//--- Makefile
SIM     ?= verilator
TOP     ?= tb_rv_core
FLIST   ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert

SRCS := rv_params.svh rv_pkg.sv rv_decode.sv rv_regfile.sv rv_alu.sv rv_exu_pc.sv \
        rv_ctrl_fsm.sv rv_perf_counter.sv rv_core.sv tb_rv_properties.sv tb_rv_core.sv
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
